/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_rx -o sim_tb_rx
./obj_dir/sim_tb_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished cleanly"

/* rx_cfg_regs.sv */
`timescale 1ns/1ps
`include "rx_config.svh"

module rx_cfg_regs (
	input  logic                 clk,
	input  logic                 rstb,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [`RX_WB_AW-1:0] wb_adr_i,
	input  logic [`RX_WB_DW-1:0] wb_dat_i,
	output logic [`RX_WB_DW-1:0] wb_dat_o,
	output logic                 wb_ack_o,
	coef_if.src                  coef
);
	import rx_pkg::*;

	wb_state_e            state;
	logic                 armed;  // stb was seen low since the last ack
	logic                 req;
	logic                 we_q;
	reg_addr_e            adr_q;
	logic [`RX_WB_DW-1:0] dat_q;
	logic [`RX_WB_DW-1:0] rd_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus handshake
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign req      = wb_cyc_i && wb_stb_i && armed && (state == WB_IDLE);
	assign wb_ack_o = (state == WB_ACK);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= WB_IDLE;
			armed <= 1'b1;
		end else begin
			case (state)
				WB_IDLE: begin
					if (req) begin
						state <= WB_ACK;
					end
				end
				default: begin
					state <= WB_IDLE;  // ack lasts one cycle
				end
			endcase
			armed <= req ? 1'b0 : (armed || !wb_stb_i);
		end
	end

	// request is captured on the accept edge, so the master may drop it during ack
	always_ff @(posedge clk) begin
		if (req) begin
			we_q     <= wb_we_i;
			adr_q    <= reg_addr_e'(wb_adr_i);
			dat_q    <= wb_dat_i;
			wb_dat_o <= rd_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register file
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		rd_data = '0;  // unknown addresses read zero
		case (reg_addr_e'(wb_adr_i))
			ADDR_W0:     rd_data[`RX_WEIGHT_W-1:0] = coef.weights[0];
			ADDR_W1:     rd_data[`RX_WEIGHT_W-1:0] = coef.weights[1];
			ADDR_W2:     rd_data[`RX_WEIGHT_W-1:0] = coef.weights[2];
			ADDR_SHIFT:  rd_data[`RX_SHIFT_W-1:0]  = coef.shift;
			ADDR_THRESH: rd_data[`RX_CODE_W-1:0]   = coef.thresh;
			ADDR_H0:     rd_data[`RX_EST_W-1:0]    = coef.h0;
			ADDR_H1:     rd_data[`RX_EST_W-1:0]    = coef.h1;
			default:     rd_data = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int t = 0; t < `RX_TAPS; t++) begin
				coef.weights[t] <= '0;
			end
			coef.shift  <= '0;
			coef.thresh <= '0;
			coef.h0     <= '0;
			coef.h1     <= '0;
		end else if (wb_ack_o && we_q) begin  // commit at the end of the ack cycle
			case (adr_q)
				ADDR_W0:     coef.weights[0] <= dat_q[`RX_WEIGHT_W-1:0];
				ADDR_W1:     coef.weights[1] <= dat_q[`RX_WEIGHT_W-1:0];
				ADDR_W2:     coef.weights[2] <= dat_q[`RX_WEIGHT_W-1:0];
				ADDR_SHIFT:  coef.shift      <= dat_q[`RX_SHIFT_W-1:0];
				ADDR_THRESH: coef.thresh     <= dat_q[`RX_CODE_W-1:0];
				ADDR_H0:     coef.h0         <= dat_q[`RX_EST_W-1:0];
				ADDR_H1:     coef.h1         <= dat_q[`RX_EST_W-1:0];
				default:     ;
			endcase
		end
	end

endmodule

/* rx_code_history.sv */
`timescale 1ns/1ps
`include "rx_config.svh"

module rx_code_history (
	input  logic                            clk,
	input  logic                            rstb,
	input  logic [`RX_LANES*`RX_CODE_W-1:0] codes_i,
	code_if.src                             codes
);
	import rx_pkg::*;

	localparam int NSYM = 2 * `RX_LANES;

	code_t cur_q  [`RX_LANES];  // word sampled on the last edge
	code_t prev_q [`RX_LANES];
	code_t dly1_q [`RX_LANES];
	code_t dly2_q [`RX_LANES];  // lines up with the tentative word under check
	code_t flat   [NSYM];

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			cur_q  <= '{default: '0};
			prev_q <= '{default: '0};
			dly1_q <= '{default: '0};
			dly2_q <= '{default: '0};
		end else begin
			for (int l = 0; l < `RX_LANES; l++) begin
				cur_q[l] <= codes_i[l*`RX_CODE_W +: `RX_CODE_W];
			end
			prev_q <= cur_q;
			dly1_q <= prev_q;
			dly2_q <= dly1_q;
		end
	end

	// two words in symbol order, previous word first
	always_comb begin
		for (int l = 0; l < `RX_LANES; l++) begin
			flat[l]           = prev_q[l];
			flat[`RX_LANES+l] = cur_q[l];
		end
		for (int l = 0; l < `RX_LANES; l++) begin
			for (int t = 0; t < `RX_TAPS; t++) begin
				codes.ffe_win[l][t] = flat[`RX_LANES+l-t];  // early lanes reach into prev_q
			end
			codes.mlsd_codes[l] = dly2_q[l];
		end
		codes.mlsd_codes[`RX_LANES] = dly1_q[0];
	end

endmodule

/* rx_config.svh */
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RX_LANES     4   // symbols per word, lane 0 is the earliest
`define RX_CODE_W    8   // signed ADC code and equalized value
`define RX_TAPS      3   // FFE taps, tap 0 is the current symbol

`define RX_WEIGHT_W  8   // signed FFE weight
`define RX_SHIFT_W   4   // FFE arithmetic right shift
`define RX_EST_W     8   // signed channel estimate tap, code domain

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RX_WB_AW     4
`define RX_WB_DW     16

`endif

/* rx_ffe.sv */
`timescale 1ns/1ps
`include "rx_config.svh"

module rx_ffe (
	input  logic          clk,
	input  logic          rstb,
	coef_if.ffe_sink      coef,
	code_if.ffe_sink      codes,
	output rx_pkg::code_t eq_o [`RX_LANES]
);
	import rx_pkg::*;

	// product width plus growth for the three-tap sum
	localparam int ACC_W  = `RX_CODE_W + `RX_WEIGHT_W + 2;
	localparam int SAT_HI = 2 ** (`RX_CODE_W - 1) - 1;
	localparam int SAT_LO = -(2 ** (`RX_CODE_W - 1));

	logic signed [ACC_W-1:0] acc     [`RX_LANES];
	logic signed [ACC_W-1:0] shifted [`RX_LANES];
	code_t                   eq_d    [`RX_LANES];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// multiply, accumulate, shift
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		for (int l = 0; l < `RX_LANES; l++) begin
			acc[l] = '0;
			for (int t = 0; t < `RX_TAPS; t++) begin
				acc[l] = acc[l] + coef.weights[t] * codes.ffe_win[l][t];  // signed, full width
			end
			shifted[l] = acc[l] >>> coef.shift;

			if (shifted[l] > SAT_HI) begin
				eq_d[l] = code_t'(SAT_HI);
			end else if (shifted[l] < SAT_LO) begin
				eq_d[l] = code_t'(SAT_LO);
			end else begin
				eq_d[l] = shifted[l][`RX_CODE_W-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			eq_o <= '{default: '0};
		end else begin
			eq_o <= eq_d;
		end
	end

endmodule

/* rx_if.sv */
`timescale 1ns/1ps
`include "rx_config.svh"

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coefficient set shared by all lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface coef_if;
	import rx_pkg::*;

	weight_t weights [`RX_TAPS];  // index is the tap, 0 is the current symbol
	shift_t  shift;
	code_t   thresh;
	est_t    h0;
	est_t    h1;

	modport src (output weights, shift, thresh, h0, h1);
	modport ffe_sink (input weights, shift);
	modport mlsd_sink (input thresh, h0, h1);

endinterface

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// aligned code windows
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface code_if;
	import rx_pkg::*;

	// [lane][tap]: tap 0 is c[k], tap 1 is c[k-1], tap 2 is c[k-2]
	code_t ffe_win [`RX_LANES][`RX_TAPS];

	// entry l is c[k] of lane l, entry RX_LANES is lane 0 of the following word
	code_t mlsd_codes [`RX_LANES+1];

	modport src (output ffe_win, mlsd_codes);
	modport ffe_sink (input ffe_win);
	modport mlsd_sink (input mlsd_codes);

endinterface

/* rx_mlsd.sv */
`timescale 1ns/1ps
`include "rx_config.svh"

module rx_mlsd (
	input  logic                 clk,
	input  logic                 rstb,
	coef_if.mlsd_sink            coef,
	code_if.mlsd_sink            codes,
	input  rx_pkg::code_t        eq_i [`RX_LANES],
	output logic [`RX_LANES-1:0] bits_o
);
	import rx_pkg::*;

	// two estimate levels plus a code, with sign and headroom
	localparam int ERR_W = `RX_CODE_W + 3;

	typedef logic signed [ERR_W-1:0] err_t;

	logic [`RX_LANES-1:0] t_q;     // tentative bits of the look-ahead word
	logic [`RX_LANES-1:0] t_prev;  // tentative bits of the word under check
	logic                 t_last;  // last lane of the word before that
	logic [`RX_LANES+1:0] t_seq;
	logic [`RX_LANES-1:0] chk;
	err_t                 err0 [`RX_LANES];
	err_t                 err1 [`RX_LANES];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hypothesis error
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic err_t level(input logic b, input est_t h);
		return b ? err_t'(h) : -err_t'(h);
	endfunction

	function automatic err_t mag(input err_t v);
		return (v < 0) ? -v : v;
	endfunction

	// b sits at k as cursor, then at k+1 as post-cursor
	function automatic err_t hyp_err(
		input logic  b,
		input logic  t_pre,
		input logic  t_nxt,
		input code_t c_k,
		input code_t c_nxt,
		input est_t  h0,
		input est_t  h1
	);
		err_t e_k;
		err_t e_nxt;
		e_k   = err_t'(c_k) - (level(b, h0) + level(t_pre, h1));
		e_nxt = err_t'(c_nxt) - (level(t_nxt, h0) + level(b, h1));
		return mag(e_k) + mag(e_nxt);
	endfunction

	// bit l+1 is t[k] of lane l, so l and l+2 are its neighbours
	assign t_seq = {t_q[0], t_prev, t_last};

	always_comb begin
		for (int l = 0; l < `RX_LANES; l++) begin
			err0[l] = hyp_err(1'b0, t_seq[l], t_seq[l+2],
				codes.mlsd_codes[l], codes.mlsd_codes[l+1], coef.h0, coef.h1);
			err1[l] = hyp_err(1'b1, t_seq[l], t_seq[l+2],
				codes.mlsd_codes[l], codes.mlsd_codes[l+1], coef.h0, coef.h1);

			if (err1[l] < err0[l]) begin
				chk[l] = 1'b1;
			end else if (err0[l] < err1[l]) begin
				chk[l] = 1'b0;
			end else begin
				chk[l] = t_seq[l+1];  // a tie keeps the slicer decision
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// slicer and bit pipeline
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			t_q    <= '0;
			t_prev <= '0;
			t_last <= 1'b0;
			bits_o <= '0;
		end else begin
			for (int l = 0; l < `RX_LANES; l++) begin
				t_q[l] <= (eq_i[l] >= coef.thresh);  // signed compare
			end
			t_prev <= t_q;
			t_last <= t_prev[`RX_LANES-1];
			bits_o <= chk;
		end
	end

endmodule

/* rx_pkg.sv */
`include "rx_config.svh"

package rx_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath value types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic signed [`RX_CODE_W-1:0]   code_t;
	typedef logic signed [`RX_WEIGHT_W-1:0] weight_t;
	typedef logic        [`RX_SHIFT_W-1:0]  shift_t;  // shift amount is unsigned
	typedef logic signed [`RX_EST_W-1:0]    est_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register map and bus FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [`RX_WB_AW-1:0] {
		ADDR_W0     = 4'h0,  // weight on the current symbol
		ADDR_W1     = 4'h1,
		ADDR_W2     = 4'h2,
		ADDR_SHIFT  = 4'h3,
		ADDR_THRESH = 4'h4,
		ADDR_H0     = 4'h5,  // cursor estimate
		ADDR_H1     = 4'h6   // post-cursor estimate
	} reg_addr_e;

	typedef enum logic {
		WB_IDLE,
		WB_ACK
	} wb_state_e;

endpackage

/* rx_props.sv */
`timescale 1ns/1ps

module rx_props (
	input logic clk,
	input logic rstb,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_o
);
	int fail_cnt = 0;

	ack_single: assert property (@(posedge clk) disable iff (!rstb) wb_ack_o |=> !wb_ack_o)
		else begin
			$error("ack stayed high for two cycles");
			fail_cnt++;
		end

	// ack answers a request seen on the previous edge
	ack_after_req: assert property (@(posedge clk) disable iff (!rstb)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
		else begin
			$error("ack without a preceding cyc and stb");
			fail_cnt++;
		end

	ack_in_reset: assert property (@(posedge clk) !rstb |-> !wb_ack_o)
		else begin
			$error("ack high while rstb is low");
			fail_cnt++;
		end

endmodule

/* rx_top.sv */
`timescale 1ns/1ps
`include "rx_config.svh"

module rx_top (
	input  logic                            clk,
	input  logic                            rstb,
	input  logic [`RX_LANES*`RX_CODE_W-1:0] codes_i,   // lane i at bits i*8 and up

	input  logic                            wb_cyc_i,
	input  logic                            wb_stb_i,
	input  logic                            wb_we_i,
	input  logic [`RX_WB_AW-1:0]            wb_adr_i,
	input  logic [`RX_WB_DW-1:0]            wb_dat_i,
	output logic [`RX_WB_DW-1:0]            wb_dat_o,
	output logic                            wb_ack_o,

	output logic [`RX_LANES-1:0]            bits_o
);
	import rx_pkg::*;

	code_t eq [`RX_LANES];  // registered FFE output

	coef_if coef_bus ();
	code_if code_bus ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	rx_cfg_regs u_cfg_regs (
		.clk      (clk),
		.rstb     (rstb),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.coef     (coef_bus.src)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	rx_code_history u_code_history (
		.clk     (clk),
		.rstb    (rstb),
		.codes_i (codes_i),
		.codes   (code_bus.src)
	);

	rx_ffe u_ffe (
		.clk   (clk),
		.rstb  (rstb),
		.coef  (coef_bus.ffe_sink),
		.codes (code_bus.ffe_sink),
		.eq_o  (eq)
	);

	rx_mlsd u_mlsd (
		.clk    (clk),
		.rstb   (rstb),
		.coef   (coef_bus.mlsd_sink),
		.codes  (code_bus.mlsd_sink),
		.eq_i   (eq),
		.bits_o (bits_o)
	);

endmodule

/* tb.f */
+incdir+.
rx_pkg.sv
rx_if.sv
rx_cfg_regs.sv
rx_code_history.sv
rx_ffe.sv
rx_mlsd.sv
rx_top.sv
rx_props.sv
tb_rx.sv

/* tb_rx.sv */
`timescale 1ns/1ps
`include "rx_config.svh"

module tb_rx;
	import rx_pkg::*;

	localparam int LOG_N     = 2048;  // edges kept by the reference model
	localparam int NREG      = 7;
	localparam int WORDS     = 400;   // longest stream of a single test
	localparam int NUM_TESTS = 6;
	localparam int BUS_CYC   = 300;

	logic                            clk;
	logic                            rstb;
	logic [`RX_LANES*`RX_CODE_W-1:0] codes_i;
	logic                            wb_cyc_i;
	logic                            wb_stb_i;
	logic                            wb_we_i;
	logic [`RX_WB_AW-1:0]            wb_adr_i;
	logic [`RX_WB_DW-1:0]            wb_dat_i;
	logic [`RX_WB_DW-1:0]            wb_dat_o;
	logic                            wb_ack_o;
	logic [`RX_LANES-1:0]            bits_o;

	logic signed [`RX_CODE_W-1:0] sym_code [LOG_N*`RX_LANES];  // codes in stream order
	logic [`RX_WB_DW-1:0]         shadow   [NREG];
	logic [`RX_WB_DW-1:0]         coef_log [LOG_N][NREG];      // register values seen at each edge
	logic [`RX_WB_DW-1:0]         pend_val;
	int                           pend_addr, pend_edge;
	bit                           pend_valid, chk_on, sign_mode;
	int                           edge_n = 0;
	int                           chk_from, n_checks, data_errs, reg_errs, rst_errs;
	int                           next_rnd;  // code word drawn on the rising edge
	integer                       seed;
	string                        test_name;

	rx_top u_rx_top (
		.clk      (clk),
		.rstb     (rstb),
		.codes_i  (codes_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.bits_o   (bits_o)
	);

	bind rx_cfg_regs rx_props u_props (
		.clk      (clk),
		.rstb     (rstb),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_ack_o (wb_ack_o)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic int sx8(input logic [`RX_WB_DW-1:0] v);
		return int'($signed(v[7:0]));
	endfunction

	function automatic logic [`RX_WB_DW-1:0] reg_mask(input int a);
		if (a == ADDR_SHIFT) return 16'h000f;
		return (a < NREG) ? 16'h00ff : 16'h0000;
	endfunction

	function automatic int abs_val(input int v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic int sym_level(input bit b, input int h);
		return b ? h : -h;
	endfunction

	function automatic int eq_val(input int s);
		int e;
		int acc;
		e   = s / `RX_LANES + 1;  // weights in effect at the FFE register edge
		acc = sx8(coef_log[e][0]) * sym_code[s] + sx8(coef_log[e][1]) * sym_code[s-1]
			+ sx8(coef_log[e][2]) * sym_code[s-2];
		acc = acc >>> coef_log[e][3][3:0];
		if (acc > 127) return 127;
		if (acc < -128) return -128;
		return acc;
	endfunction

	function automatic bit slice_bit(input int s);
		return eq_val(s) >= sx8(coef_log[s / `RX_LANES + 2][4]);
	endfunction

	function automatic bit checked_bit(input int s);
		int e, h0, h1, err0, err1;
		bit tp, tn;
		e    = s / `RX_LANES + 4;
		h0   = sx8(coef_log[e][5]);
		h1   = sx8(coef_log[e][6]);
		tp   = slice_bit(s - 1);
		tn   = slice_bit(s + 1);
		err0 = abs_val(sym_code[s] - (sym_level(0, h0) + sym_level(tp, h1)))
			+ abs_val(sym_code[s+1] - (sym_level(tn, h0) + sym_level(0, h1)));
		err1 = abs_val(sym_code[s] - (sym_level(1, h0) + sym_level(tp, h1)))
			+ abs_val(sym_code[s+1] - (sym_level(tn, h0) + sym_level(1, h1)));
		if (err1 < err0) return 1'b1;
		if (err0 < err1) return 1'b0;
		return slice_bit(s);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus master
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic bus_access(input logic we, input logic [`RX_WB_AW-1:0] a,
		input logic [`RX_WB_DW-1:0] d, output logic [`RX_WB_DW-1:0] q);
		@(negedge clk);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = a;
		wb_dat_i = d;
		@(negedge clk);
		while (!wb_ack_o) begin
			@(negedge clk);
		end
		q = wb_dat_o;
		if (we && a < NREG) begin
			pend_addr  = a;
			pend_val   = d & reg_mask(a);
			pend_edge  = edge_n + 2;  // register commits on the edge after ack
			pend_valid = 1'b1;
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic bus_write(input int a, input logic [`RX_WB_DW-1:0] d);
		logic [`RX_WB_DW-1:0] q;
		bus_access(1'b1, a[`RX_WB_AW-1:0], d, q);
	endtask

	task automatic configure_random();
		for (int a = 0; a < NREG; a++) begin
			bus_write(a, (a == ADDR_SHIFT) ? 16'($random(seed) & 7) : 16'($random(seed)));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) edge_n <= edge_n + 1;

	always @(posedge clk) next_rnd = $random(seed);

	// checks the word from four edges back and logs the coefficients for the next word it drives
	always @(negedge clk) begin
		int n;
		logic [`RX_LANES-1:0] exp_bits;
		logic [`RX_LANES-1:0] sign_bits;
		n = edge_n - 4;
		if (chk_on && n >= chk_from) begin
			for (int l = 0; l < `RX_LANES; l++) begin
				exp_bits[l]  = checked_bit(n * `RX_LANES + l);
				sign_bits[l] = (sym_code[n * `RX_LANES + l] >= 0);
			end
			n_checks++;
			if (bits_o !== exp_bits) begin
				data_errs++;
				$display("FAIL %s: word %0d expected %b actual %b",
					test_name, n, exp_bits, bits_o);
			end
			if (sign_mode && bits_o !== sign_bits) begin
				data_errs++;
				$display("FAIL %s: word %0d sign rule expected %b actual %b",
					test_name, n, sign_bits, bits_o);
			end
		end
		if (pend_valid && edge_n + 1 >= pend_edge) begin
			shadow[pend_addr] = pend_val;
			pend_valid        = 1'b0;
		end
		coef_log[edge_n+1] = shadow;
		codes_i = next_rnd;
		for (int l = 0; l < `RX_LANES; l++) begin
			sym_code[(edge_n + 1) * `RX_LANES + l] = next_rnd[l*`RX_CODE_W +: `RX_CODE_W];
		end
	end

	initial begin
		#((WORDS * NUM_TESTS + BUS_CYC) * 40 * 2);
		$display("watchdog expired, the DUT stopped answering");
		$display("TEST FAILED");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		logic [`RX_WB_DW-1:0] wr_val [NREG];
		logic [`RX_WB_DW-1:0] rd;
		logic [`RX_WB_DW-1:0] exp_q;
		int                   total;
		seed      = 32'h7cfff875;
		rstb      = 1'b0;
		codes_i   = '0;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		shadow    = '{default: '0};
		test_name = "reset";

		for (int i = 0; i < 9; i++) begin  // eight cycles in reset and one after
			@(negedge clk);
			if (bits_o !== '0 || wb_ack_o !== 1'b0) begin
				rst_errs++;
				$display("FAIL %s: expected bits_o 0 ack 0, actual bits_o %b ack %b",
					test_name, bits_o, wb_ack_o);
			end
			if (i == 7) begin
				rstb     = 1'b1;
				chk_from = edge_n + 3;
			end
		end
		chk_on = 1'b1;

		test_name = "readback";
		for (int a = 0; a < NREG; a++) begin
			wr_val[a] = 16'($random(seed));
			bus_write(a, wr_val[a]);
		end
		for (int a = 0; a < 16; a++) begin
			bus_access(1'b0, a[`RX_WB_AW-1:0], '0, rd);
			exp_q = (a < NREG) ? (wr_val[a] & reg_mask(a)) : '0;
			if (rd !== exp_q) begin
				reg_errs++;
				$display("FAIL %s: addr %0h expected %h actual %h", test_name, a, exp_q, rd);
			end
		end

		test_name = "identity";
		bus_write(ADDR_W0, 16'd1);
		bus_write(ADDR_W1, 16'd0);
		bus_write(ADDR_W2, 16'd0);
		bus_write(ADDR_SHIFT, 16'd0);
		bus_write(ADDR_THRESH, 16'd0);
		bus_write(ADDR_H0, 16'd100);
		bus_write(ADDR_H1, 16'd0);
		repeat (8) @(negedge clk);
		sign_mode = 1'b1;
		repeat (200) @(negedge clk);
		sign_mode = 1'b0;

		test_name = "random";
		configure_random();
		repeat (WORDS) @(negedge clk);

		test_name = "tie";
		bus_write(ADDR_H0, 16'd0);
		bus_write(ADDR_H1, 16'd0);
		repeat (200) @(negedge clk);

		test_name = "thresh_change";
		configure_random();
		repeat (100) @(negedge clk);
		bus_write(ADDR_THRESH, 16'($random(seed)));
		repeat (300) @(negedge clk);
		repeat (8) @(negedge clk);

		total = data_errs + reg_errs + rst_errs + u_rx_top.u_cfg_regs.u_props.fail_cnt;
		$display({"checks %0d, datapath errors %0d, register errors %0d, ",
			"reset errors %0d, assertion failures %0d"},
			n_checks, data_errs, reg_errs, rst_errs, u_rx_top.u_cfg_regs.u_props.fail_cnt);
		if (total == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
